//--- design/mm_ram_pkg.sv
// memory model package: sizes, memory map, status codes and shared types
package mm_ram_pkg;

    // ----------------------------------------
    // sizes
    // ----------------------------------------
    localparam int RAM_ADDR_WIDTH = 12;
    localparam int DBG_ADDR_WIDTH = 8;
    localparam int XLEN           = 32;
    localparam int IRQ_WIDTH      = 32;
    localparam int IRQ_ID_WIDTH   = $clog2(IRQ_WIDTH);
    localparam int RAM_WORDS      = 2 ** (RAM_ADDR_WIDTH - 2);

    localparam logic [31:0] RAM_BYTES = 32'd1 << RAM_ADDR_WIDTH;
    localparam logic [31:0] DBG_BYTES = 32'd1 << DBG_ADDR_WIDTH;
    // debug code lives in the last DBG_BYTES of RAM
    localparam logic [RAM_ADDR_WIDTH-1:0] DBG_BASE = RAM_ADDR_WIDTH'(RAM_BYTES - DBG_BYTES);

    // ----------------------------------------
    // memory map
    // ----------------------------------------
    localparam logic [31:0] MMADDR_TESTSTATUS = 32'h2000_0000;
    localparam logic [31:0] MMADDR_EXIT       = 32'h2000_0004;
    localparam logic [31:0] MMADDR_TIMERREG   = 32'h1500_0000;
    localparam logic [31:0] MMADDR_TIMERVAL   = 32'h1500_0004;
    localparam logic [31:0] MMADDR_DBG        = 32'h1500_0008;
    localparam logic [31:0] MMADDR_TICKS      = 32'h1500_1004;

    localparam logic [31:0] TEST_PASS_CODE = 32'd123456789;
    localparam logic [31:0] TEST_FAIL_CODE = 32'd1;

    // debug control word fields
    localparam int DBG_VALUE_BIT = 31;
    localparam int DBG_PULSE_BIT = 30;
    localparam int DBG_DUR_MSB   = 28;
    localparam int DBG_DUR_LSB   = 16;
    localparam int DBG_DLY_MSB   = 14;
    localparam int DBG_DLY_LSB   = 0;

    typedef enum logic [1:0] {RSEL_RAM, RSEL_TICKS, RSEL_ERR} mm_rsel_e;

    typedef enum logic [1:0] {PER_TIMER_MASK, PER_TIMER_VAL, PER_DBG, PER_TICKS_CLR} mm_per_e;

    typedef struct packed {
        logic            valid;
        mm_per_e         target;
        logic [XLEN-1:0] wdata;
    } mm_per_wr_t;

endpackage

//--- design/mm_ram_bus_if.sv
// decoded data-port access from the address decoder to the RAM
`timescale 1ns/10ps

interface mm_ram_bus_if;

    logic                                req;
    logic                                we;
    logic [mm_ram_pkg::XLEN/8-1:0]       be;
    logic [mm_ram_pkg::RAM_ADDR_WIDTH-1:0] addr;
    logic [mm_ram_pkg::XLEN-1:0]         wdata;
    // read data, one cycle after req
    logic [mm_ram_pkg::XLEN-1:0]         rdata;

    modport ctrl (
        output req, we, be, addr, wdata,
        input  rdata
    );

    modport mem (
        input  req, we, be, addr, wdata,
        output rdata
    );

endinterface

//--- design/mm_addr_decode.sv
// address decoder: splits data requests into RAM, peripheral and status accesses
`timescale 1ns/10ps

module mm_addr_decode (
    input  logic                                  data_req_i,
    input  logic [31:0]                           data_addr_i,
    input  logic                                  data_we_i,
    input  logic [mm_ram_pkg::XLEN/8-1:0]         data_be_i,
    input  logic [mm_ram_pkg::XLEN-1:0]           data_wdata_i,
    input  logic [31:0]                           instr_addr_i,
    input  logic [31:0]                           dm_halt_addr_i,
    mm_ram_bus_if.ctrl                            bus,
    output logic [mm_ram_pkg::RAM_ADDR_WIDTH-1:0] instr_ram_addr_o,
    output mm_ram_pkg::mm_per_wr_t                per_wr_o,
    output mm_ram_pkg::mm_rsel_e                  rsel_o,
    output logic                                  tests_passed_o,
    output logic                                  tests_failed_o,
    output logic                                  exit_valid_o,
    output logic [mm_ram_pkg::XLEN-1:0]           exit_value_o
);

    function automatic logic in_dbg(input logic [31:0] addr, input logic [31:0] base);
        // unsigned offset also rejects addresses below the base
        return (addr - base) < mm_ram_pkg::DBG_BYTES;
    endfunction

    function automatic logic [mm_ram_pkg::RAM_ADDR_WIDTH-1:0] remap(
        input logic [31:0] addr,
        input logic [31:0] base
    );
        logic [31:0] off;
        off = addr - base;
        if (in_dbg(addr, base)) begin
            return off[mm_ram_pkg::RAM_ADDR_WIDTH-1:0] + mm_ram_pkg::DBG_BASE;
        end
        return addr[mm_ram_pkg::RAM_ADDR_WIDTH-1:0];
    endfunction

    logic data_is_ram;

    assign data_is_ram = (data_addr_i < mm_ram_pkg::RAM_BYTES) ||
                         in_dbg(data_addr_i, dm_halt_addr_i);

    assign instr_ram_addr_o = remap(instr_addr_i, dm_halt_addr_i);

    assign bus.we    = data_we_i;
    assign bus.be    = data_be_i;
    assign bus.wdata = data_wdata_i;
    assign bus.addr  = remap(data_addr_i, dm_halt_addr_i);

    always_comb begin
        bus.req         = 1'b0;
        per_wr_o.valid  = 1'b0;
        per_wr_o.target = mm_ram_pkg::PER_TIMER_MASK;
        per_wr_o.wdata  = data_wdata_i;
        rsel_o          = mm_ram_pkg::RSEL_RAM;
        tests_passed_o  = 1'b0;
        tests_failed_o  = 1'b0;
        exit_valid_o    = 1'b0;
        exit_value_o    = '0;

        // gnt follows req, so every request is taken here
        if (data_req_i && data_is_ram) begin
            bus.req = 1'b1;
        end else if (data_req_i && data_we_i) begin
            per_wr_o.valid = 1'b1;
            case (data_addr_i)
                mm_ram_pkg::MMADDR_TIMERREG: per_wr_o.target = mm_ram_pkg::PER_TIMER_MASK;
                mm_ram_pkg::MMADDR_TIMERVAL: per_wr_o.target = mm_ram_pkg::PER_TIMER_VAL;
                mm_ram_pkg::MMADDR_DBG:      per_wr_o.target = mm_ram_pkg::PER_DBG;
                mm_ram_pkg::MMADDR_TICKS:    per_wr_o.target = mm_ram_pkg::PER_TICKS_CLR;
                mm_ram_pkg::MMADDR_TESTSTATUS: begin
                    per_wr_o.valid = 1'b0;
                    tests_passed_o = (data_wdata_i == mm_ram_pkg::TEST_PASS_CODE);
                    tests_failed_o = (data_wdata_i == mm_ram_pkg::TEST_FAIL_CODE);
                end
                mm_ram_pkg::MMADDR_EXIT: begin
                    per_wr_o.valid = 1'b0;
                    exit_valid_o   = 1'b1;
                    exit_value_o   = data_wdata_i;
                end
                // unmapped write is dropped
                default: per_wr_o.valid = 1'b0;
            endcase
        end else if (data_req_i) begin
            rsel_o = (data_addr_i == mm_ram_pkg::MMADDR_TICKS) ? mm_ram_pkg::RSEL_TICKS
                                                               : mm_ram_pkg::RSEL_ERR;
        end
    end

endmodule

//--- design/mm_dp_ram.sv
// dual-port RAM, read-only instruction port and byte-enabled data port
`timescale 1ns/10ps

module mm_dp_ram (
    input  logic                                  clk_i,
    input  logic                                  instr_req_i,
    input  logic [mm_ram_pkg::RAM_ADDR_WIDTH-1:0] instr_addr_i,
    output logic [mm_ram_pkg::XLEN-1:0]           instr_rdata_o,
    mm_ram_bus_if.mem                             bus
);

    logic [mm_ram_pkg::XLEN-1:0] mem [mm_ram_pkg::RAM_WORDS];

    logic [mm_ram_pkg::RAM_ADDR_WIDTH-3:0] instr_word;
    logic [mm_ram_pkg::RAM_ADDR_WIDTH-3:0] data_word;

    // byte address to word index
    assign instr_word = instr_addr_i[mm_ram_pkg::RAM_ADDR_WIDTH-1:2];
    assign data_word  = bus.addr[mm_ram_pkg::RAM_ADDR_WIDTH-1:2];

    always_ff @(posedge clk_i) begin
        if (instr_req_i) begin
            instr_rdata_o <= mem[instr_word];
        end
    end

    always_ff @(posedge clk_i) begin
        if (bus.req) begin
            // read returns the old word, a write's rdata is not used
            bus.rdata <= mem[data_word];
            if (bus.we) begin
                for (int b = 0; b < mm_ram_pkg::XLEN / 8; b++) begin
                    if (bus.be[b]) begin
                        mem[data_word][8*b +: 8] <= bus.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

//--- design/mm_timers.sv
// interrupt countdown timer with per-bit acknowledge, and the tick counter
`timescale 1ns/10ps

module mm_timers (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  mm_ram_pkg::mm_per_wr_t              per_wr_i,
    input  logic [mm_ram_pkg::IRQ_ID_WIDTH-1:0] irq_id_i,
    input  logic                                irq_ack_i,
    output logic [mm_ram_pkg::IRQ_WIDTH-1:0]    irq_o,
    output logic [mm_ram_pkg::XLEN-1:0]         ticks_o
);

    logic [mm_ram_pkg::IRQ_WIDTH-1:0] mask_q;
    logic [mm_ram_pkg::XLEN-1:0]      cnt_q;

    logic mask_wr;
    logic val_wr;
    logic clr_wr;

    assign mask_wr = per_wr_i.valid && (per_wr_i.target == mm_ram_pkg::PER_TIMER_MASK);
    assign val_wr  = per_wr_i.valid && (per_wr_i.target == mm_ram_pkg::PER_TIMER_VAL);
    assign clr_wr  = per_wr_i.valid && (per_wr_i.target == mm_ram_pkg::PER_TICKS_CLR);

    // ----------------------------------------
    // interrupt timer
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q <= '0;
            cnt_q  <= '0;
            irq_o  <= '0;
        end else begin
            if (mask_wr) begin
                mask_q <= per_wr_i.wdata[mm_ram_pkg::IRQ_WIDTH-1:0];
            end

            if (val_wr) begin
                cnt_q <= per_wr_i.wdata;
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end

            // expiry wins over an acknowledge in the same cycle
            if (cnt_q == 1) begin
                irq_o <= mask_q;
            end else if (irq_ack_i) begin
                irq_o[irq_id_i] <= 1'b0;
            end
        end
    end

    // ----------------------------------------
    // tick counter
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ticks_o <= '0;
        end else if (clr_wr) begin
            // the clear cycle itself is tick zero
            ticks_o <= 1;
        end else begin
            ticks_o <= ticks_o + 1'b1;
        end
    end

endmodule

//--- design/mm_debug_req.sv
// debug request sequencer: delayed level change or pulse on debug_req_o
`timescale 1ns/10ps

module mm_debug_req (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  mm_ram_pkg::mm_per_wr_t per_wr_i,
    output logic                   debug_req_o
);

    logic [mm_ram_pkg::DBG_DLY_MSB-mm_ram_pkg::DBG_DLY_LSB:0] wr_delay;
    logic [mm_ram_pkg::DBG_DLY_MSB-mm_ram_pkg::DBG_DLY_LSB:0] delay_q;
    logic [mm_ram_pkg::DBG_DUR_MSB-mm_ram_pkg::DBG_DUR_LSB:0] wr_width;
    logic [mm_ram_pkg::DBG_DUR_MSB-mm_ram_pkg::DBG_DUR_LSB:0] width_q;
    logic                                                     value_q;
    logic                                                     start;

    assign wr_delay = per_wr_i.wdata[mm_ram_pkg::DBG_DLY_MSB:mm_ram_pkg::DBG_DLY_LSB];
    assign wr_width = per_wr_i.wdata[mm_ram_pkg::DBG_DUR_MSB:mm_ram_pkg::DBG_DUR_LSB];

    // only an idle sequencer takes a new control word
    assign start = per_wr_i.valid && (per_wr_i.target == mm_ram_pkg::PER_DBG) &&
                   (delay_q == '0) && (width_q == '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            delay_q     <= '0;
            width_q     <= '0;
            value_q     <= 1'b0;
            debug_req_o <= 1'b0;
        end else if (start) begin
            // zero delay and zero width both count as one
            delay_q <= (wr_delay == '0) ? 1 : wr_delay;
            value_q <= per_wr_i.wdata[mm_ram_pkg::DBG_VALUE_BIT];
            if (!per_wr_i.wdata[mm_ram_pkg::DBG_PULSE_BIT]) begin
                width_q <= '0;
            end else begin
                width_q <= (wr_width == '0) ? 1 : wr_width;
            end
        end else if (delay_q != '0) begin
            delay_q <= delay_q - 1'b1;
            if (delay_q == 1) begin
                debug_req_o <= value_q;
            end
        end else if (width_q != '0) begin
            width_q <= width_q - 1'b1;
            if (width_q == 1) begin
                debug_req_o <= !value_q;
            end
        end
    end

endmodule

//--- design/mm_read_return.sv
// response side: rvalid generation and data-port read mux
`timescale 1ns/10ps

module mm_read_return (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        data_req_i,
    input  logic                        instr_req_i,
    input  mm_ram_pkg::mm_rsel_e        rsel_i,
    input  logic [mm_ram_pkg::XLEN-1:0] ram_rdata_i,
    input  logic [mm_ram_pkg::XLEN-1:0] ticks_i,
    output logic                        data_rvalid_o,
    output logic [mm_ram_pkg::XLEN-1:0] data_rdata_o,
    output logic                        instr_rvalid_o
);

    mm_ram_pkg::mm_rsel_e        rsel_q;
    logic [mm_ram_pkg::XLEN-1:0] ticks_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            data_rvalid_o  <= 1'b0;
            instr_rvalid_o <= 1'b0;
            rsel_q         <= mm_ram_pkg::RSEL_RAM;
        end else begin
            data_rvalid_o  <= data_req_i;
            instr_rvalid_o <= instr_req_i;
            if (data_req_i) begin
                rsel_q <= rsel_i;
            end
        end
    end

    // tick value as seen at the grant edge
    always_ff @(posedge clk_i) begin
        if (data_req_i && (rsel_i == mm_ram_pkg::RSEL_TICKS)) begin
            ticks_q <= ticks_i;
        end
    end

    always_comb begin
        case (rsel_q)
            mm_ram_pkg::RSEL_RAM:   data_rdata_o = ram_rdata_i;
            mm_ram_pkg::RSEL_TICKS: data_rdata_o = ticks_q;
            // error reads return zero
            default:                data_rdata_o = '0;
        endcase
    end

endmodule

//--- design/mm_ram.sv
// memory and pseudo-peripheral model for the core testbench
`timescale 1ns/10ps

module mm_ram (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic [31:0]                         dm_halt_addr_i,

    input  logic                                instr_req_i,
    input  logic [31:0]                         instr_addr_i,
    output logic                                instr_gnt_o,
    output logic                                instr_rvalid_o,
    output logic [mm_ram_pkg::XLEN-1:0]         instr_rdata_o,

    input  logic                                data_req_i,
    input  logic [31:0]                         data_addr_i,
    input  logic                                data_we_i,
    input  logic [mm_ram_pkg::XLEN/8-1:0]       data_be_i,
    input  logic [mm_ram_pkg::XLEN-1:0]         data_wdata_i,
    output logic                                data_gnt_o,
    output logic                                data_rvalid_o,
    output logic [mm_ram_pkg::XLEN-1:0]         data_rdata_o,

    input  logic [mm_ram_pkg::IRQ_ID_WIDTH-1:0] irq_id_i,
    input  logic                                irq_ack_i,
    output logic [mm_ram_pkg::IRQ_WIDTH-1:0]    irq_o,
    output logic                                debug_req_o,

    output logic                                tests_passed_o,
    output logic                                tests_failed_o,
    output logic                                exit_valid_o,
    output logic [mm_ram_pkg::XLEN-1:0]         exit_value_o
);

    mm_ram_bus_if bus ();

    logic [mm_ram_pkg::RAM_ADDR_WIDTH-1:0] instr_ram_addr;
    mm_ram_pkg::mm_per_wr_t                per_wr;
    mm_ram_pkg::mm_rsel_e                  rsel;
    logic [mm_ram_pkg::XLEN-1:0]           ticks;

    // no back-pressure on either port
    assign instr_gnt_o = instr_req_i;
    assign data_gnt_o  = data_req_i;

    mm_addr_decode i_decode (
        .data_req_i       (data_req_i),
        .data_addr_i      (data_addr_i),
        .data_we_i        (data_we_i),
        .data_be_i        (data_be_i),
        .data_wdata_i     (data_wdata_i),
        .instr_addr_i     (instr_addr_i),
        .dm_halt_addr_i   (dm_halt_addr_i),
        .bus              (bus.ctrl),
        .instr_ram_addr_o (instr_ram_addr),
        .per_wr_o         (per_wr),
        .rsel_o           (rsel),
        .tests_passed_o   (tests_passed_o),
        .tests_failed_o   (tests_failed_o),
        .exit_valid_o     (exit_valid_o),
        .exit_value_o     (exit_value_o)
    );

    mm_dp_ram i_ram (
        .clk_i         (clk_i),
        .instr_req_i   (instr_req_i),
        .instr_addr_i  (instr_ram_addr),
        .instr_rdata_o (instr_rdata_o),
        .bus           (bus.mem)
    );

    mm_timers i_timers (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .per_wr_i  (per_wr),
        .irq_id_i  (irq_id_i),
        .irq_ack_i (irq_ack_i),
        .irq_o     (irq_o),
        .ticks_o   (ticks)
    );

    mm_debug_req i_debug_req (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .per_wr_i    (per_wr),
        .debug_req_o (debug_req_o)
    );

    mm_read_return i_read_return (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .data_req_i     (data_req_i),
        .instr_req_i    (instr_req_i),
        .rsel_i         (rsel),
        .ram_rdata_i    (bus.rdata),
        .ticks_i        (ticks),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .instr_rvalid_o (instr_rvalid_o)
    );

endmodule

//--- test/tb_mm_ram.sv
// testbench for the memory model covering RAM, debug window, timer, debug request and status
`timescale 1ns/10ps

module tb_mm_ram;

    localparam logic [31:0] HALT_ADDR = 32'h1A11_0800;
    localparam logic [31:0] UNMAPPED  = 32'h3000_0000;
    localparam logic [31:0] DBG_PLAIN = (32'd1 << mm_ram_pkg::RAM_ADDR_WIDTH) -
                                        (32'd1 << mm_ram_pkg::DBG_ADDR_WIDTH);
    localparam int unsigned TIMEOUT   = 200;

    logic        clk_i;
    logic        rst_ni;
    logic [31:0] dm_halt_addr_i;
    logic        instr_req_i;
    logic [31:0] instr_addr_i;
    logic        instr_gnt_o;
    logic        instr_rvalid_o;
    logic [31:0] instr_rdata_o;
    logic        data_req_i;
    logic [31:0] data_addr_i;
    logic        data_we_i;
    logic [3:0]  data_be_i;
    logic [31:0] data_wdata_i;
    logic        data_gnt_o;
    logic        data_rvalid_o;
    logic [31:0] data_rdata_o;
    logic [mm_ram_pkg::IRQ_ID_WIDTH-1:0] irq_id_i;
    logic        irq_ack_i;
    logic [31:0] irq_o;
    logic        debug_req_o;
    logic        tests_passed_o;
    logic        tests_failed_o;
    logic        exit_valid_o;
    logic [31:0] exit_value_o;

    logic [31:0] seed;
    logic [31:0] shadow [1024];
    int unsigned cyc;
    int unsigned last_grant;
    int          errors;
    int          checks;
    int          tests_done;
    int          errors_at_start;
    logic        seen_passed;
    logic        seen_failed;
    logic        seen_exit_valid;
    logic [31:0] seen_exit_value;

    mm_ram i_dut (.*);

    always #50 clk_i = ~clk_i;

    // posedge counter sampled at negedges
    always @(posedge clk_i) cyc <= cyc + 1;

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  be);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic handshake_error(input string msg);
        errors++;
        $display("handshake error: %s", msg);
    endtask

    task automatic give_up(input string what);
        $display("timeout: %s", what);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic finish_test(input string name);
        tests_done++;
        $display("test %s done, %0d errors", name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    // one data-port transfer with status outputs sampled in the request cycle
    task automatic bus_xfer(input logic we, input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        int unsigned n;
        @(posedge clk_i);
        data_req_i   <= 1'b1;
        data_we_i    <= we;
        data_addr_i  <= addr;
        data_be_i    <= be;
        data_wdata_i <= wdata;
        @(negedge clk_i);
        last_grant      = cyc + 1;
        seen_passed     = tests_passed_o;
        seen_failed     = tests_failed_o;
        seen_exit_valid = exit_valid_o;
        seen_exit_value = exit_value_o;
        @(posedge clk_i);
        data_req_i <= 1'b0;
        data_we_i  <= 1'b0;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (!data_rvalid_o && n < TIMEOUT);
        if (!data_rvalid_o) give_up("data_rvalid_o never came");
        rdata = data_rdata_o;
    endtask

    task automatic fetch(input logic [31:0] addr, output logic [31:0] rdata);
        int unsigned n;
        @(posedge clk_i);
        instr_req_i  <= 1'b1;
        instr_addr_i <= addr;
        @(posedge clk_i);
        instr_req_i <= 1'b0;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
        end while (!instr_rvalid_o && n < TIMEOUT);
        if (!instr_rvalid_o) give_up("instr_rvalid_o never came");
        rdata = instr_rdata_o;
    endtask

    task automatic wait_irq(input logic [31:0] exp, input int unsigned start,
                            output int unsigned elapsed);
        do begin
            @(negedge clk_i);
        end while (irq_o !== exp && cyc - start < TIMEOUT);
        if (irq_o !== exp) give_up("irq_o never took the timer mask");
        elapsed = cyc - start;
    endtask

    task automatic wait_debug(input logic exp, input int unsigned start,
                              output int unsigned elapsed);
        do begin
            @(negedge clk_i);
        end while (debug_req_o !== exp && cyc - start < TIMEOUT);
        if (debug_req_o !== exp) give_up("debug_req_o never changed");
        elapsed = cyc - start;
    endtask

    // ----------------------------------------
    // handshake checks
    // ----------------------------------------
    assert property (@(posedge clk_i) disable iff (!rst_ni) data_gnt_o == data_req_i)
        else handshake_error("data_gnt_o differs from data_req_i");
    assert property (@(posedge clk_i) disable iff (!rst_ni) instr_gnt_o == instr_req_i)
        else handshake_error("instr_gnt_o differs from instr_req_i");
    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     data_rvalid_o == $past(data_gnt_o))
        else handshake_error("data_rvalid_o did not follow the grant by one cycle");
    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     instr_rvalid_o == $past(instr_gnt_o))
        else handshake_error("instr_rvalid_o did not follow the grant by one cycle");

    initial begin
        logic [31:0] rnd;
        logic [31:0] addr;
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] rd;
        logic [31:0] mask;
        logic [31:0] ctrl;
        logic [31:0] off;
        logic [3:0]  be;
        logic [4:0]  id;
        int unsigned el;
        int unsigned delay;
        int unsigned width;
        int unsigned clr_grant;
        logic [31:0] addr_q [$];

        clk_i = 1'b0;
        rst_ni = 1'b0;
        instr_req_i = 1'b0;
        instr_addr_i = '0;
        data_req_i = 1'b0;
        data_addr_i = '0;
        data_we_i = 1'b0;
        data_be_i = '0;
        data_wdata_i = '0;
        irq_id_i = '0;
        irq_ack_i = 1'b0;
        dm_halt_addr_i = HALT_ADDR;
        seed = 32'h72779f63;
        cyc = 0;
        errors = 0;
        checks = 0;
        tests_done = 0;
        errors_at_start = 0;

        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;

        // RAM round trip against the shadow model
        for (int i = 0; i < 16; i++) begin
            rnd = next_random();
            addr = {21'd0, rnd[8:0], 2'b00};
            be = rnd[15:12];
            w0 = next_random();
            w1 = next_random();
            bus_xfer(1'b1, addr, 4'hF, w0, rd);
            shadow[addr[11:2]] = w0;
            bus_xfer(1'b1, addr, be, w1, rd);
            shadow[addr[11:2]] = merge_bytes(shadow[addr[11:2]], w1, be);
            bus_xfer(1'b0, addr, 4'hF, '0, rd);
            check_value("ram round trip", shadow[addr[11:2]], rd);
            addr_q.push_back(addr);
        end
        foreach (addr_q[k]) begin
            bus_xfer(1'b0, addr_q[k], 4'hF, '0, rd);
            check_value("ram read back", shadow[addr_q[k][11:2]], rd);
        end
        finish_test("ram");

        // debug window at the top of RAM
        rnd = next_random();
        off = {24'd0, rnd[7:2], 2'b00};
        w0 = next_random();
        bus_xfer(1'b1, HALT_ADDR + off, 4'hF, w0, rd);
        bus_xfer(1'b0, DBG_PLAIN + off, 4'hF, '0, rd);
        check_value("debug window data read", w0, rd);
        fetch(HALT_ADDR + off, rd);
        check_value("debug window fetch", w0, rd);
        fetch(DBG_PLAIN + off, rd);
        check_value("debug window plain fetch", w0, rd);
        finish_test("debug window");

        // timer
        mask = next_random();
        rnd = next_random();
        id = rnd[4:0];
        mask[id] = 1'b1;
        delay = 3 + rnd[10:8];
        bus_xfer(1'b1, mm_ram_pkg::MMADDR_TIMERREG, 4'hF, mask, rd);
        bus_xfer(1'b1, mm_ram_pkg::MMADDR_TIMERVAL, 4'hF, delay, rd);
        wait_irq(mask, last_grant, el);
        check_value("timer delay", delay, el);
        @(posedge clk_i);
        irq_ack_i <= 1'b1;
        irq_id_i  <= id;
        @(posedge clk_i);
        irq_ack_i <= 1'b0;
        @(negedge clk_i);
        check_value("irq acknowledge", mask & ~(32'd1 << id), irq_o);
        finish_test("timer");

        // debug request, level then pulse
        rnd = next_random();
        delay = 2 + rnd[3:0];
        ctrl = '0;
        ctrl[mm_ram_pkg::DBG_VALUE_BIT] = 1'b1;
        ctrl[mm_ram_pkg::DBG_DLY_MSB:mm_ram_pkg::DBG_DLY_LSB] = delay;
        bus_xfer(1'b1, mm_ram_pkg::MMADDR_DBG, 4'hF, ctrl, rd);
        wait_debug(1'b1, last_grant, el);
        check_value("debug level delay", delay, el);
        delay = 1 + rnd[7:4];
        width = 1 + rnd[11:8];
        ctrl = '0;
        ctrl[mm_ram_pkg::DBG_PULSE_BIT] = 1'b1;
        ctrl[mm_ram_pkg::DBG_DUR_MSB:mm_ram_pkg::DBG_DUR_LSB] = width;
        ctrl[mm_ram_pkg::DBG_DLY_MSB:mm_ram_pkg::DBG_DLY_LSB] = delay;
        bus_xfer(1'b1, mm_ram_pkg::MMADDR_DBG, 4'hF, ctrl, rd);
        wait_debug(1'b0, last_grant, el);
        check_value("debug pulse delay", delay, el);
        clr_grant = cyc;
        wait_debug(1'b1, clr_grant, el);
        check_value("debug pulse width", width, el);
        finish_test("debug request");

        // status, exit, ticks and unmapped reads
        bus_xfer(1'b1, mm_ram_pkg::MMADDR_TESTSTATUS, 4'hF, mm_ram_pkg::TEST_PASS_CODE, rd);
        check_value("pass code passed", 1'b1, seen_passed);
        check_value("pass code failed", 1'b0, seen_failed);
        bus_xfer(1'b1, mm_ram_pkg::MMADDR_TESTSTATUS, 4'hF, mm_ram_pkg::TEST_FAIL_CODE, rd);
        check_value("fail code failed", 1'b1, seen_failed);
        check_value("fail code passed", 1'b0, seen_passed);
        w0 = next_random();
        bus_xfer(1'b1, mm_ram_pkg::MMADDR_EXIT, 4'hF, w0, rd);
        check_value("exit valid", 1'b1, seen_exit_valid);
        check_value("exit value", w0, seen_exit_value);
        bus_xfer(1'b1, mm_ram_pkg::MMADDR_TICKS, 4'hF, '0, rd);
        clr_grant = last_grant;
        rnd = next_random();
        repeat (rnd[2:0]) @(posedge clk_i);
        bus_xfer(1'b0, mm_ram_pkg::MMADDR_TICKS, 4'hF, '0, rd);
        check_value("tick count", last_grant - clr_grant, rd);
        bus_xfer(1'b0, UNMAPPED, 4'hF, '0, rd);
        check_value("unmapped read", 32'd0, rd);
        finish_test("status and ticks");

        $display("summary: %0d tests, %0d checks, %0d errors", tests_done, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
design/mm_ram_pkg.sv
design/mm_ram_bus_if.sv
design/mm_addr_decode.sv
design/mm_dp_ram.sv
design/mm_timers.sv
design/mm_debug_req.sv
design/mm_read_return.sv
design/mm_ram.sv
test/tb_mm_ram.sv

//--- Bender.yml
package:
  name: mm_ram

sources:
  - design/mm_ram_pkg.sv
  - design/mm_ram_bus_if.sv
  - design/mm_addr_decode.sv
  - design/mm_dp_ram.sv
  - design/mm_timers.sv
  - design/mm_debug_req.sv
  - design/mm_read_return.sv
  - design/mm_ram.sv
  - target: test
    files:
      - test/tb_mm_ram.sv
